/* serv_cfg.svh */
`ifndef SERV_CFG_SVH
`define SERV_CFG_SVH

`define SERV_XLEN     32
`define SERV_REG_AW   5
`define SERV_CNT_W    5
`define SERV_RESET_PC 32'h0000_0000

// Major opcodes of the kept instructions
`define SERV_OPC_OP    7'b0110011
`define SERV_OPC_OPIMM 7'b0010011
`define SERV_OPC_LUI   7'b0110111
`define SERV_OPC_AUIPC 7'b0010111

`define SERV_F3_ADD 3'b000
`define SERV_F3_XOR 3'b100
`define SERV_F3_OR  3'b110
`define SERV_F3_AND 3'b111

`define SERV_OPA_RS1  2'd0
`define SERV_OPA_PC   2'd1
`define SERV_OPA_ZERO 2'd2

// Low two bits of funct3
`define SERV_BOOL_XOR 2'b00
`define SERV_BOOL_OR  2'b10
`define SERV_BOOL_AND 2'b11

`endif

/* serv_pkg.sv */
`default_nettype none

`include "serv_cfg.svh"

package serv_pkg;

   // Fetched instruction word
   typedef logic [`SERV_XLEN-1:0] instr_t;

   // Fetch address and PC
   typedef logic [`SERV_XLEN-1:0] pc_t;

   typedef logic [`SERV_REG_AW-1:0] reg_addr_t;

   // Bit position within the serial run
   typedef logic [`SERV_CNT_W-1:0] cnt_t;

   // Operand A source as a SERV_OPA_* code
   typedef logic [1:0] op_a_sel_t;

   // Boolean unit function as a SERV_BOOL_* code
   typedef logic [1:0] bool_op_t;

   // One instruction in flight
   typedef enum logic [1:0] {
      FETCH,
      RF_REQ,
      RF_WAIT,
      RUN
   } state_t;

endpackage

`default_nettype wire

/* serv_state.sv */
`timescale 1ns/10ps
`default_nettype none

module serv_state (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   input  logic i_rd_write,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_wen0,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt2
);

   import serv_pkg::*;

   state_t state;
   state_t state_nxt;
   cnt_t   cnt;
   logic   run;
   logic   cnt_last;

   assign run      = (state == RUN);
   assign cnt_last = (cnt == '1);

   always_comb begin
      state_nxt = state;
      case (state)
         FETCH: begin
            if (o_ibus_cyc && i_ibus_ack) begin
               state_nxt = RF_REQ;
            end
         end
         RF_REQ: begin
            state_nxt = RF_WAIT;
         end
         RF_WAIT: begin
            if (i_rf_ready) begin
               state_nxt = RUN;
            end
         end
         RUN: begin
            if (cnt_last) begin
               state_nxt = FETCH;
            end
         end
         default: begin
            state_nxt = FETCH;
         end
      endcase
   end

   // Bus cycle is registered so it stays low through reset
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state      <= FETCH;
         o_ibus_cyc <= 1'b0;
         cnt        <= '0;
      end else begin
         state      <= state_nxt;
         o_ibus_cyc <= (state_nxt == FETCH);
         if (run) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // Single request cycle right after the acknowledge
   assign o_rf_rreq = (state == RF_REQ);

   assign o_cnt_en = run;
   assign o_cnt0   = run && (cnt == cnt_t'(0));
   assign o_cnt2   = run && (cnt == cnt_t'(2));

   assign o_wen0 = run && i_rd_write;

endmodule

`default_nettype wire

/* serv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serv_cfg.svh"

module serv_decode (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_ibus_ack,
   input  serv_pkg::instr_t     i_ibus_rdt,
   input  logic                 i_cnt_en,
   output serv_pkg::reg_addr_t  o_rs1_addr,
   output serv_pkg::reg_addr_t  o_rs2_addr,
   output serv_pkg::reg_addr_t  o_rd_addr,
   output logic                 o_rd_write,
   output logic                 o_imm,
   output logic                 o_op_b_imm,
   output serv_pkg::op_a_sel_t  o_op_a_sel,
   output logic                 o_alu_sub,
   output logic                 o_alu_bool,
   output serv_pkg::bool_op_t   o_bool_op
);

   import serv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rd_field;
   logic       f3_arith;
   logic       is_op;
   logic       is_opimm;
   logic       is_lui;
   logic       is_auipc;
   logic       utype;
   op_a_sel_t  op_a_nxt;
   instr_t     imm_fmt;
   instr_t     imm_sr;

   assign opcode   = i_ibus_rdt[6:0];
   assign funct3   = i_ibus_rdt[14:12];
   assign funct7   = i_ibus_rdt[31:25];
   assign rd_field = i_ibus_rdt[11:7];

   assign f3_arith = (funct3 == `SERV_F3_ADD) || (funct3 == `SERV_F3_XOR) ||
                     (funct3 == `SERV_F3_OR)  || (funct3 == `SERV_F3_AND);

   // Only funct7 of zero, or SUB, is a kept register-register op
   assign is_op    = (opcode == `SERV_OPC_OP) && f3_arith &&
                     ((funct7 == 7'h00) ||
                      ((funct7 == 7'h20) && (funct3 == `SERV_F3_ADD)));
   assign is_opimm = (opcode == `SERV_OPC_OPIMM) && f3_arith;
   assign is_lui   = (opcode == `SERV_OPC_LUI);
   assign is_auipc = (opcode == `SERV_OPC_AUIPC);
   assign utype    = is_lui || is_auipc;

   always_comb begin
      if (is_auipc) begin
         op_a_nxt = `SERV_OPA_PC;
      end else if (is_lui) begin
         op_a_nxt = `SERV_OPA_ZERO;
      end else begin
         op_a_nxt = `SERV_OPA_RS1;
      end
   end

   // U-type upper 20 bits, else sign-extended I-type
   assign imm_fmt = utype ? {i_ibus_rdt[31:12], 12'b0} :
                            {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rd_write <= 1'b0;
         o_op_b_imm <= 1'b0;
         o_op_a_sel <= `SERV_OPA_RS1;
         o_alu_sub  <= 1'b0;
         o_alu_bool <= 1'b0;
         o_bool_op  <= `SERV_BOOL_XOR;
      end else if (i_ibus_ack) begin
         o_rd_write <= (is_op || is_opimm || utype) && (rd_field != '0);
         o_op_b_imm <= !is_op;
         o_op_a_sel <= op_a_nxt;
         o_alu_sub  <= is_op && i_ibus_rdt[30] && (funct3 == `SERV_F3_ADD);
         o_alu_bool <= (is_op || is_opimm) && (funct3 != `SERV_F3_ADD);
         o_bool_op  <= funct3[1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rs1_addr <= i_ibus_rdt[19:15];
         o_rs2_addr <= i_ibus_rdt[24:20];
         o_rd_addr  <= rd_field;
         imm_sr     <= imm_fmt;
      end else if (i_cnt_en) begin
         imm_sr <= {1'b0, imm_sr[`SERV_XLEN-1:1]};
      end
   end

   assign o_imm = imm_sr[0];

endmodule

`default_nettype wire

/* serv_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serv_cfg.svh"

module serv_ctrl #(
   parameter serv_pkg::pc_t RESET_PC = `SERV_RESET_PC
) (
   input  logic          clk,
   input  logic          i_rst_n,
   input  logic          i_cnt_en,
   input  logic          i_cnt0,
   input  logic          i_cnt2,
   output logic          o_pc_bit,
   output serv_pkg::pc_t o_ibus_adr
);

   import serv_pkg::*;

   pc_t  pc;
   logic carry;
   logic carry_in;
   logic inc_bit;
   logic sum;

   // The constant 4 is a single one at bit 2
   assign inc_bit  = i_cnt2;
   assign carry_in = carry && !i_cnt0;
   assign sum      = pc[0] ^ inc_bit ^ carry_in;

   // Rotates once per run cycle and ends up holding pc+4
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc    <= RESET_PC;
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         pc    <= {sum, pc[`SERV_XLEN-1:1]};
         carry <= (pc[0] && inc_bit) || (carry_in && (pc[0] ^ inc_bit));
      end
   end

   assign o_pc_bit   = pc[0];
   assign o_ibus_adr = pc;

endmodule

`default_nettype wire

/* serv_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serv_cfg.svh"

module serv_alu (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_cnt_en,
   input  logic                i_cnt0,
   input  logic                i_rs1,
   input  logic                i_rs2,
   input  logic                i_imm,
   input  logic                i_pc,
   input  logic                i_op_b_imm,
   input  serv_pkg::op_a_sel_t i_op_a_sel,
   input  logic                i_sub,
   input  logic                i_bool,
   input  serv_pkg::bool_op_t  i_bool_op,
   output logic                o_rd
);

   import serv_pkg::*;

   logic op_a;
   logic op_b;
   logic carry;
   logic carry_in;
   logic sum;
   logic bool_res;

   always_comb begin
      case (i_op_a_sel)
         `SERV_OPA_RS1: op_a = i_rs1;
         `SERV_OPA_PC:  op_a = i_pc;
         default:       op_a = 1'b0;
      endcase
   end

   // Subtraction as a + ~b + 1
   assign op_b     = (i_op_b_imm ? i_imm : i_rs2) ^ i_sub;
   assign carry_in = i_cnt0 ? i_sub : carry;
   assign sum      = op_a ^ op_b ^ carry_in;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         carry <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= (op_a && op_b) || (carry_in && (op_a ^ op_b));
      end
   end

   always_comb begin
      case (i_bool_op)
         `SERV_BOOL_XOR: bool_res = op_a ^ op_b;
         `SERV_BOOL_OR:  bool_res = op_a | op_b;
         `SERV_BOOL_AND: bool_res = op_a & op_b;
         default:        bool_res = 1'b0;
      endcase
   end

   assign o_rd = i_bool ? bool_res : sum;

endmodule

`default_nettype wire

/* serv_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serv_cfg.svh"

module serv_top #(
   parameter serv_pkg::pc_t RESET_PC = `SERV_RESET_PC
) (
   input  logic                clk,
   input  logic                i_rst_n,
   // Instruction bus
   output serv_pkg::pc_t       o_ibus_adr,
   output logic                o_ibus_cyc,
   input  serv_pkg::instr_t    i_ibus_rdt,
   input  logic                i_ibus_ack,
   // Register file
   output logic                o_rf_rreq,
   input  logic                i_rf_ready,
   output serv_pkg::reg_addr_t o_rreg0,
   output serv_pkg::reg_addr_t o_rreg1,
   input  logic                i_rdata0,
   input  logic                i_rdata1,
   output serv_pkg::reg_addr_t o_wreg0,
   output logic                o_wen0,
   output logic                o_wdata0
);

   import serv_pkg::*;

   logic      cnt_en;
   logic      cnt0;
   logic      cnt2;
   logic      rd_write;
   logic      imm;
   logic      op_b_imm;
   op_a_sel_t op_a_sel;
   logic      alu_sub;
   logic      alu_bool;
   bool_op_t  bool_op;
   logic      pc_bit;

   serv_state u_state (
      .clk        (clk        ),
      .i_rst_n    (i_rst_n    ),
      .i_ibus_ack (i_ibus_ack ),
      .i_rf_ready (i_rf_ready ),
      .i_rd_write (rd_write   ),
      .o_ibus_cyc (o_ibus_cyc ),
      .o_rf_rreq  (o_rf_rreq  ),
      .o_wen0     (o_wen0     ),
      .o_cnt_en   (cnt_en     ),
      .o_cnt0     (cnt0       ),
      .o_cnt2     (cnt2       )
   );

   serv_decode u_decode (
      .clk        (clk        ),
      .i_rst_n    (i_rst_n    ),
      .i_ibus_ack (i_ibus_ack ),
      .i_ibus_rdt (i_ibus_rdt ),
      .i_cnt_en   (cnt_en     ),
      .o_rs1_addr (o_rreg0    ),
      .o_rs2_addr (o_rreg1    ),
      .o_rd_addr  (o_wreg0    ),
      .o_rd_write (rd_write   ),
      .o_imm      (imm        ),
      .o_op_b_imm (op_b_imm   ),
      .o_op_a_sel (op_a_sel   ),
      .o_alu_sub  (alu_sub    ),
      .o_alu_bool (alu_bool   ),
      .o_bool_op  (bool_op    )
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk        (clk        ),
      .i_rst_n    (i_rst_n    ),
      .i_cnt_en   (cnt_en     ),
      .i_cnt0     (cnt0       ),
      .i_cnt2     (cnt2       ),
      .o_pc_bit   (pc_bit     ),
      .o_ibus_adr (o_ibus_adr )
   );

   serv_alu u_alu (
      .clk        (clk        ),
      .i_rst_n    (i_rst_n    ),
      .i_cnt_en   (cnt_en     ),
      .i_cnt0     (cnt0       ),
      .i_rs1      (i_rdata0   ),
      .i_rs2      (i_rdata1   ),
      .i_imm      (imm        ),
      .i_pc       (pc_bit     ),
      .i_op_b_imm (op_b_imm   ),
      .i_op_a_sel (op_a_sel   ),
      .i_sub      (alu_sub    ),
      .i_bool     (alu_bool   ),
      .i_bool_op  (bool_op    ),
      .o_rd       (o_wdata0   )
   );

endmodule

`default_nettype wire

/* tb_serv_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serv_cfg.svh"

module tb_serv_top;

   localparam int          N_INSTR    = 200;
   localparam int          CLK_PERIOD = 20;
   localparam int          TIMEOUT_NS = N_INSTR * 45 * CLK_PERIOD * 2;
   localparam logic [31:0] RESET_PC   = `SERV_RESET_PC;
   localparam logic [31:0] SEED       = 32'hba3e;
   localparam logic [31:0] NOP_WORD   = {12'h000, 5'd0, `SERV_F3_ADD, 5'd0, `SERV_OPC_OPIMM};

   logic        clk = 1'b0;
   logic        rst_n = 1'b1;
   logic [31:0] i_ibus_rdt = 32'h0;
   logic        i_ibus_ack = 1'b0;
   logic        i_rf_ready = 1'b0;
   logic        i_rdata0 = 1'b0;
   logic        i_rdata1 = 1'b0;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic        o_rf_rreq;
   logic [4:0]  o_rreg0;
   logic [4:0]  o_rreg1;
   logic [4:0]  o_wreg0;
   logic        o_wen0;
   logic        o_wdata0;

   logic [31:0] prog [N_INSTR];
   logic [31:0] init_regs [32];
   logic [31:0] regs [32];
   logic [31:0] cur_instr;
   logic [31:0] cur_pc;
   logic [31:0] exp_pc;
   logic [31:0] rs1_val;
   logic [31:0] rs2_val;
   logic [31:0] exp_word;
   logic [31:0] got_word;
   logic [31:0] wr_word;
   logic        exp_wen;
   logic        running;
   logic        commit;
   logic        rdy_pend;
   logic [1:0]  ack_wait;
   logic [1:0]  rdy_wait;
   logic [1:0]  rdy_cnt;
   logic [4:0]  bitpos;
   int          errors = 0;
   int          done_cnt = 0;

   task automatic value_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("failure at %0t: %s", $time, what);
   endtask

   // Kept instructions plus a few unsupported encodings
   task automatic random_instr(output logic [31:0] w);
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      logic [19:0] uimm;
      logic [3:0]  kind;
      rd   = 5'($urandom);
      rs1  = 5'($urandom);
      rs2  = 5'($urandom);
      imm  = 12'($urandom);
      uimm = 20'($urandom);
      kind = 4'($urandom % 13);
      if (($urandom % 8) == 0) begin
         rd = 5'd0;
      end
      case (kind)
         4'd0:    w = {7'h00, rs2, rs1, `SERV_F3_ADD, rd, `SERV_OPC_OP};
         4'd1:    w = {7'h20, rs2, rs1, `SERV_F3_ADD, rd, `SERV_OPC_OP};
         4'd2:    w = {7'h00, rs2, rs1, `SERV_F3_AND, rd, `SERV_OPC_OP};
         4'd3:    w = {7'h00, rs2, rs1, `SERV_F3_OR, rd, `SERV_OPC_OP};
         4'd4:    w = {7'h00, rs2, rs1, `SERV_F3_XOR, rd, `SERV_OPC_OP};
         4'd5:    w = {imm, rs1, `SERV_F3_ADD, rd, `SERV_OPC_OPIMM};
         4'd6:    w = {imm, rs1, `SERV_F3_AND, rd, `SERV_OPC_OPIMM};
         4'd7:    w = {imm, rs1, `SERV_F3_OR, rd, `SERV_OPC_OPIMM};
         4'd8:    w = {imm, rs1, `SERV_F3_XOR, rd, `SERV_OPC_OPIMM};
         4'd9:    w = {uimm, rd, `SERV_OPC_LUI};
         4'd10:   w = {uimm, rd, `SERV_OPC_AUIPC};
         // Shift left is not kept
         4'd11:   w = {7'h00, rs2, rs1, 3'b001, rd, `SERV_OPC_OP};
         // Load word is not kept
         default: w = {imm, rs1, 3'b010, rd, 7'b0000011};
      endcase
   endtask

   function automatic logic [31:0] program_word(input logic [31:0] adr);
      logic [31:0] idx;
      idx = (adr - RESET_PC) >> 2;
      if (idx < N_INSTR) begin
         program_word = prog[idx[7:0]];
      end else begin
         program_word = NOP_WORD;
      end
   endfunction

   function automatic logic [31:0] expected_result(input logic [31:0] ins,
                                                   input logic [31:0] pc,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
      logic [31:0] imm_i;
      logic [31:0] imm_u;
      logic [31:0] op_b;
      logic        is_op;
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_u = {ins[31:12], 12'h000};
      is_op = (ins[6:0] == `SERV_OPC_OP);
      op_b  = is_op ? b : imm_i;
      case (ins[6:0])
         `SERV_OPC_LUI:   expected_result = imm_u;
         `SERV_OPC_AUIPC: expected_result = pc + imm_u;
         default: begin
            case (ins[14:12])
               `SERV_F3_ADD: expected_result = (is_op && ins[30]) ? a - op_b : a + op_b;
               `SERV_F3_XOR: expected_result = a ^ op_b;
               `SERV_F3_OR:  expected_result = a | op_b;
               `SERV_F3_AND: expected_result = a & op_b;
               default:      expected_result = 32'h0;
            endcase
         end
      endcase
   endfunction

   function automatic logic writes_rd(input logic [31:0] ins);
      logic kept_f3;
      logic kept;
      kept_f3 = (ins[14:12] == `SERV_F3_ADD) || (ins[14:12] == `SERV_F3_XOR) ||
                (ins[14:12] == `SERV_F3_OR) || (ins[14:12] == `SERV_F3_AND);
      case (ins[6:0])
         `SERV_OPC_OP:    kept = kept_f3 && ((ins[31:25] == 7'h00) ||
                                 ((ins[31:25] == 7'h20) && (ins[14:12] == `SERV_F3_ADD)));
         `SERV_OPC_OPIMM: kept = kept_f3;
         `SERV_OPC_LUI:   kept = 1'b1;
         `SERV_OPC_AUIPC: kept = 1'b1;
         default:         kept = 1'b0;
      endcase
      writes_rd = kept && (ins[11:7] != 5'd0);
   endfunction

   serv_top #(
      .RESET_PC (RESET_PC)
   ) u_serv_top (
      .clk        (clk        ),
      .i_rst_n    (rst_n      ),
      .o_ibus_adr (o_ibus_adr ),
      .o_ibus_cyc (o_ibus_cyc ),
      .i_ibus_rdt (i_ibus_rdt ),
      .i_ibus_ack (i_ibus_ack ),
      .o_rf_rreq  (o_rf_rreq  ),
      .i_rf_ready (i_rf_ready ),
      .o_rreg0    (o_rreg0    ),
      .o_rreg1    (o_rreg1    ),
      .i_rdata0   (i_rdata0   ),
      .i_rdata1   (i_rdata1   ),
      .o_wreg0    (o_wreg0    ),
      .o_wen0     (o_wen0     ),
      .o_wdata0   (o_wdata0   )
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      rst_n <= 1'b0;
      void'($urandom(SEED));
      for (int i = 0; i < N_INSTR; i++) begin
         random_instr(prog[i]);
      end
      for (int i = 0; i < 32; i++) begin
         init_regs[i] = (i == 0) ? 32'h0 : $urandom;
      end
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      wait (done_cnt == N_INSTR);
      repeat (3) @(posedge clk);
      $display("%0d errors in %0d instructions", errors, done_cnt);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the core stopped before finishing the program");
      $display("TESTBENCH FAILED");
      $finish;
   end

   // Instruction memory with a random acknowledge delay
   always @(posedge clk) begin
      if (!rst_n) begin
         i_ibus_ack <= 1'b0;
         ack_wait   <= 2'd0;
         exp_pc     <= RESET_PC;
      end else begin
         i_ibus_ack <= 1'b0;
         if (i_ibus_ack) begin
            exp_pc <= exp_pc + 32'd4;
         end
         if (o_ibus_cyc && !i_ibus_ack) begin
            if (ack_wait == 2'd0) begin
               i_ibus_ack <= 1'b1;
               i_ibus_rdt <= program_word(o_ibus_adr);
               cur_instr  <= program_word(o_ibus_adr);
               cur_pc     <= exp_pc;
               ack_wait   <= 2'($urandom % 4);
            end else begin
               ack_wait <= ack_wait - 2'd1;
            end
         end
      end
   end

   // Register file, serial read and write ports
   always @(posedge clk) begin
      if (!rst_n) begin
         i_rf_ready <= 1'b0;
         rdy_wait   <= 2'd0;
         rdy_pend   <= 1'b0;
         rdy_cnt    <= 2'd0;
         running    <= 1'b0;
         commit     <= 1'b0;
         bitpos     <= 5'd0;
         for (int i = 0; i < 32; i++) begin
            regs[i] <= init_regs[i];
         end
      end else begin
         i_rf_ready <= 1'b0;
         commit     <= 1'b0;
         if (o_rf_rreq) begin
            rs1_val  <= regs[o_rreg0];
            rs2_val  <= regs[o_rreg1];
            exp_word <= expected_result(cur_instr, cur_pc, regs[cur_instr[19:15]],
                                        regs[cur_instr[24:20]]);
            exp_wen  <= writes_rd(cur_instr);
            if (rdy_wait == 2'd0) begin
               i_rf_ready <= 1'b1;
            end else begin
               rdy_pend <= 1'b1;
               rdy_cnt  <= rdy_wait;
            end
            rdy_wait <= 2'($urandom % 3);
         end else if (rdy_pend) begin
            if (rdy_cnt == 2'd1) begin
               i_rf_ready <= 1'b1;
               rdy_pend   <= 1'b0;
            end
            rdy_cnt <= rdy_cnt - 2'd1;
         end
         if (i_rf_ready) begin
            running  <= 1'b1;
            bitpos   <= 5'd0;
            i_rdata0 <= rs1_val[0];
            i_rdata1 <= rs2_val[0];
         end
         if (running) begin
            wr_word[bitpos] <= o_wdata0;
            if (bitpos == 5'd31) begin
               running  <= 1'b0;
               commit   <= 1'b1;
               got_word <= {o_wdata0, wr_word[30:0]};
               done_cnt <= done_cnt + 1;
               if (o_wen0 && (o_wreg0 != 5'd0)) begin
                  regs[o_wreg0] <= {o_wdata0, wr_word[30:0]};
               end
            end else begin
               bitpos   <= bitpos + 5'd1;
               i_rdata0 <= rs1_val[bitpos + 5'd1];
               i_rdata1 <= rs2_val[bitpos + 5'd1];
            end
         end
      end
   end

   a_reset_idle: assert property (@(posedge clk)
      !rst_n |-> !o_ibus_cyc && !o_rf_rreq && !o_wen0)
      else note_failure("bus, request or write active during reset");
   a_first_fetch: assert property (@(posedge clk)
      $rose(rst_n) |=> o_ibus_cyc)
      else note_failure("no fetch in the first cycle after reset");
   a_fetch_adr: assert property (@(posedge clk) disable iff (!rst_n)
      o_ibus_cyc |-> o_ibus_adr == exp_pc)
      else value_mismatch("o_ibus_adr", $sampled(o_ibus_adr), $sampled(exp_pc));
   a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
      o_ibus_cyc && !i_ibus_ack |=> o_ibus_cyc && $stable(o_ibus_adr))
      else note_failure("fetch dropped or address moved before the acknowledge");
   a_rreq_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
      i_ibus_ack |=> o_rf_rreq)
      else note_failure("no register request in the cycle after the acknowledge");
   a_rreq_source: assert property (@(posedge clk) disable iff (!rst_n)
      o_rf_rreq |-> $past(i_ibus_ack))
      else note_failure("register request without a preceding acknowledge");
   a_rreg: assert property (@(posedge clk) disable iff (!rst_n)
      o_rf_rreq |-> {o_rreg0, o_rreg1} == {cur_instr[19:15], cur_instr[24:20]})
      else value_mismatch("o_rreg0/o_rreg1", 32'($sampled({o_rreg0, o_rreg1})),
                          32'($sampled({cur_instr[19:15], cur_instr[24:20]})));
   a_wreg: assert property (@(posedge clk) disable iff (!rst_n)
      running |-> o_wreg0 == cur_instr[11:7])
      else value_mismatch("o_wreg0", 32'($sampled(o_wreg0)), 32'($sampled(cur_instr[11:7])));
   a_wen_run: assert property (@(posedge clk) disable iff (!rst_n)
      running |-> o_wen0 == exp_wen)
      else value_mismatch("o_wen0", 32'($sampled(o_wen0)), 32'($sampled(exp_wen)));
   a_wen_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !running |-> !o_wen0)
      else note_failure("write enable outside the 32 cycles after ready");
   a_result: assert property (@(posedge clk) disable iff (!rst_n)
      commit && exp_wen |-> got_word == exp_word)
      else value_mismatch("o_wdata0", $sampled(got_word), $sampled(exp_word));

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
serv_pkg.sv
serv_state.sv
serv_decode.sv
serv_ctrl.sv
serv_alu.sv
serv_top.sv
tb_serv_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f flist.f --top-module tb_serv_top -o tb_serv_top &&
   ./obj_dir/tb_serv_top | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
   echo "simulation passed" ||
   {
      echo "simulation failed"
      exit 1
   }
